/* src/scroll_pkg.sv */
// Shared types, bus states and register map for the scrolling tile layer; import where needed
package scroll_pkg;

    // APB register map in byte addresses
    localparam logic [11:0] ADDR_CODE_BASE = 12'h000; // 1024 tile codes
    localparam logic [11:0] ADDR_ATTR_BASE = 12'h400; // 1024 tile attributes
    localparam logic [11:0] ADDR_VSCROLL   = 12'h800; // Vertical scroll and last valid address

    // One byte of attribute RAM
    typedef struct packed {
        logic [1:0] code_hi;  // Upper tile code bits
        logic       vflip;
        logic       hflip;
        logic [3:0] palette;
    } tile_attr_t;

    // Map entry read by the fetcher
    typedef struct packed {
        logic [7:0] code;
        tile_attr_t attr;
    } tile_entry_t;

    // Eight 4-bit pixels, leftmost in the top nibble
    typedef struct packed {
        logic [31:0] pixels;
        logic        hflip;
        logic [3:0]  palette;
    } pixel_row_t;

    // Palette PROM lookup address
    typedef struct packed {
        logic [3:0] palette;
        logic [3:0] pixel;
    } pal_req_t;

    // Phase seen on the APB bus in the previous cycle
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

endpackage

/* src/tile_vram.sv */
// APB slave with tile code and attribute RAMs plus the scroll register; feeds the tile fetcher
`timescale 1ns/1ps

module tile_vram
    import scroll_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic [9:0]  map_index,
    output tile_entry_t entry,
    output logic [7:0]  vpos
);

    logic [7:0] code_ram [1024];
    logic [7:0] attr_ram [1024];
    logic [7:0] cpu_code;
    logic [7:0] cpu_attr;
    apb_state_t state;
    logic       sel_code;
    logic       sel_attr;
    logic       sel_vscr;
    logic       addr_err;
    logic       access;
    logic       wr_en;

    assign sel_code = paddr[11:10] == ADDR_CODE_BASE[11:10];
    assign sel_attr = paddr[11:10] == ADDR_ATTR_BASE[11:10];
    assign sel_vscr = paddr == ADDR_VSCROLL;
    assign addr_err = paddr > ADDR_VSCROLL;

    // Access phase that followed a proper setup phase
    assign access = psel && penable && state == apb_setup;
    assign wr_en  = access && pwrite && !addr_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= apb_idle;
        end else if (psel && !penable) begin
            state <= apb_setup;
        end else if (psel) begin
            state <= apb_access;
        end else begin
            state <= apb_idle;
        end
    end

    // Response flags set in setup so they are valid through the access phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            vpos    <= 8'h00;
        end else begin
            pready  <= psel && !penable;
            pslverr <= psel && !penable && addr_err;
            if (wr_en && sel_vscr) vpos <= pwdata;
        end
    end

    // CPU port and video read port
    always_ff @(posedge clk) begin
        if (wr_en && sel_code) code_ram[paddr[9:0]] <= pwdata;
        if (wr_en && sel_attr) attr_ram[paddr[9:0]] <= pwdata;
        cpu_code   <= code_ram[paddr[9:0]];
        cpu_attr   <= attr_ram[paddr[9:0]];
        entry.code <= code_ram[map_index];
        entry.attr <= tile_attr_t'(attr_ram[map_index]);
    end

    always_comb begin
        prdata = 8'h00;                   // Unmapped reads return zero
        if (sel_code)      prdata = cpu_code;
        else if (sel_attr) prdata = cpu_attr;
        else if (sel_vscr) prdata = vpos;
    end

    // Enable must come one cycle after a setup phase with select still held
    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel && state == apb_setup)
        else $error("penable rose without a preceding setup phase");

endmodule

/* src/tile_fetch.sv */
// Tile fetcher that forms map and graphics ROM addresses and turns ROM words into pixel rows
`timescale 1ns/1ps

module tile_fetch
    import scroll_pkg::*;
#(
    parameter int ROM_AW = 13
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              flip,
    input  logic [8:0]        hdump,
    input  logic [7:0]        vdump,
    input  logic [7:0]        vpos,
    output logic [9:0]        map_index,
    input  tile_entry_t       entry,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output pixel_row_t        row,
    output logic              row_load
);

    // Code bits above the 8-bit code and the 3 row bits
    localparam int HI_W = ROM_AW - 11;

    logic [7:0] hdf;
    logic [7:0] vscr;
    logic [7:0] vsum;
    logic [2:0] row_sel;
    logic       load_q;

    // Gather bit n of every nibble column into one pixel
    function automatic logic [31:0] reorder(input logic [31:0] d);
        logic [31:0] p;
        int          base;
        p = '0;
        for (int g = 0; g < 8; g++) begin
            base = (g < 4) ? 31 - g : 19 - g;  // Upper half first and lower half after
            p[31 - 4*g -: 4] = {d[base], d[base-4], d[base-8], d[base-12]};
        end
        return p;
    endfunction

    assign hdf       = {8{flip}} ^ hdump[7:0];
    assign vsum      = vdump + vpos;
    assign map_index = {vscr[7:3], hdf[7:3]};          // 32x32 tile map
    assign row_sel   = vscr[2:0] ^ {3{entry.attr.vflip}};
    assign row_load  = load_q && pxl_cen;

    // Scroll applies in the middle columns only so the status columns stay fixed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vscr <= 8'h00;
        end else if (pxl_cen) begin
            if (hdump[8])      vscr <= {8{flip}} ^ vdump;
            else if (hdump[5]) vscr <= {8{flip}} ^ vsum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_addr <= '0;
            load_q   <= 1'b0;
        end else if (pxl_cen) begin
            if (hdf[2:0] == 3'd0) begin
                rom_addr <= {entry.attr.code_hi[HI_W-1:0], entry.code, row_sel};
            end
            load_q <= hdf[2:0] == 3'd4; // Handed to the shifter on the next enable
        end
    end

    // ROM data has had four pixels to settle
    always_ff @(posedge clk) begin
        if (pxl_cen && hdf[2:0] == 3'd4) begin
            row.pixels  <= rom_ok ? reorder(rom_data) : 32'h0;
            row.hflip   <= entry.attr.hflip;
            row.palette <= entry.attr.palette;
        end
    end

    // Load strobe lasts a single cycle as hdump moves off the capture phase
    a_row_load_pulse: assert property (@(posedge clk) disable iff (rst)
        row_load |=> !row_load)
        else $error("row_load held for more than one cycle");

endmodule

/* src/pixel_shifter.sv */
// Pixel shifter: buffers one fetched row and sends out one pixel per enable in flip order
`timescale 1ns/1ps

module pixel_shifter
    import scroll_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       row_load,
    input  pixel_row_t row,
    output pal_req_t   req
);

    logic [31:0] data;
    logic [3:0]  pal;
    logic        hf;
    logic [3:0]  end_nib;

    // Next pixel out sits at the end that matches the flip
    assign end_nib = hf ? data[3:0] : data[31:28];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (row_load) begin
                data <= row.pixels;
                pal  <= row.palette;
            end else begin
                data <= hf ? data >> 4 : data << 4;
            end
        end
    end

    // Output stage still holds the old row's last pixel on a load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hf  <= 1'b0;
            req <= '0;
        end else if (pxl_cen) begin
            if (row_load) hf <= row.hflip;
            req.palette <= pal;
            req.pixel   <= end_nib;
        end
    end

endmodule

/* src/palette_lut.sv */
// Palette PROM: loaded over the programming port, maps palette and pixel to a colour index
`timescale 1ns/1ps

module palette_lut
    import scroll_pkg::*;
(
    input  logic       clk,
    input  logic       pxl_cen,
    input  logic       prog_en,
    input  logic [7:0] prog_addr,
    input  logic [3:0] prog_data,
    input  pal_req_t   req,
    output logic [3:0] pxl = 4'h0
);

    logic [3:0] prom [256];
    logic [7:0] rd_addr;

    assign rd_addr = {req.palette, req.pixel}; // 16 palettes of 16 colours

    // Loading is independent of the pixel enable
    always_ff @(posedge clk) begin
        if (prog_en) prom[prog_addr] <= prog_data;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) pxl <= prom[rd_addr];
    end

endmodule

/* src/scroll_layer.sv */
// Top level of the scrolling tile layer: APB tile RAM, fetcher, shifter and palette
`timescale 1ns/1ps

module scroll_layer
    import scroll_pkg::*;
#(
    parameter int ROM_AW = 13
) (
    input  logic              clk,
    input  logic              rst,
    // CPU bus
    input  logic [11:0]       paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        pwdata,
    output logic [7:0]        prdata,
    output logic              pready,
    output logic              pslverr,
    // Palette PROM loading
    input  logic [7:0]        prog_addr,
    input  logic [3:0]        prog_data,
    input  logic              prog_en,
    // Video timing
    input  logic [8:0]        hdump,
    input  logic [7:0]        vdump,
    input  logic              flip,
    input  logic              pxl_cen,
    // Graphics ROM
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output logic [3:0]        pxl
);

    logic [9:0]  map_index;
    tile_entry_t entry;
    logic [7:0]  vpos;
    pixel_row_t  row;
    logic        row_load;
    pal_req_t    req;

    tile_vram u_tile_vram (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .map_index (map_index),
        .entry     (entry),
        .vpos      (vpos)
    );

    tile_fetch #(
        .ROM_AW (ROM_AW)
    ) u_tile_fetch (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .flip      (flip),
        .hdump     (hdump),
        .vdump     (vdump),
        .vpos      (vpos),
        .map_index (map_index),
        .entry     (entry),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .row       (row),
        .row_load  (row_load)
    );

    pixel_shifter u_pixel_shifter (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .row_load (row_load),
        .row      (row),
        .req      (req)
    );

    palette_lut u_palette_lut (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .req       (req),
        .pxl       (pxl)
    );

endmodule

/* tests/tb_scroll_layer.sv */
// Directed testbench for the scroll layer that models the graphics ROM and drives APB and video
`timescale 1ns/1ps

module tb_scroll_layer
    import scroll_pkg::*;
();

    localparam int ROM_AW = 13;
    // Twice the 19k cycles of APB fill and readback plus seven lines
    localparam int MAX_CYCLES = 40000;

    typedef struct packed {
        logic [12:0] addr;
        logic        hflip;
        logic [3:0]  palette;
        logic        ok;
    } tile_rec_t;

    logic clk;
    logic rst;
    logic [11:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic pready;
    logic pslverr;
    logic [7:0] prog_addr;
    logic [3:0] prog_data;
    logic prog_en;
    logic [8:0] hdump;
    logic [7:0] vdump;
    logic flip;
    logic pxl_cen;
    logic [ROM_AW-1:0] rom_addr;
    logic [31:0] rom_data = 32'h0;
    logic rom_ok = 1'b0;
    logic [3:0] pxl;

    logic [7:0]  code_mem [1024];
    logic [7:0]  attr_mem [1024];
    logic [7:0]  vscroll_val;
    logic [7:0]  m_vscr = 8'h00;    // Row register as seen by the fetcher
    logic [12:0] exp_addr = '0;
    logic        rom_ok_en = 1'b1;
    tile_rec_t   tile_q [$];
    logic [3:0]  pxl_q [$];
    int          search_pos;
    int          cycles = 0;

    scroll_layer #(
        .ROM_AW (ROM_AW)
    ) u_scroll_layer (
        .clk (clk), .rst (rst),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .prog_addr (prog_addr), .prog_data (prog_data), .prog_en (prog_en),
        .hdump (hdump), .vdump (vdump), .flip (flip), .pxl_cen (pxl_cen),
        .rom_addr (rom_addr), .rom_data (rom_data), .rom_ok (rom_ok), .pxl (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rom_word(input logic [12:0] a);
        return {3'b000, a, 3'b000, a} ^ 32'h5a3c_96e1;
    endfunction

    // Graphics ROM answers one clock after the address
    always @(posedge clk) begin
        rom_data <= rom_word(rom_addr);
        rom_ok   <= rom_ok_en;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [ROM_AW-1:0] got,
                              input logic [ROM_AW-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pxl(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Setup and access phases followed by one idle cycle
    task automatic apb_write(input logic [11:0] addr, input logic [7:0] data, input logic err);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready", pready, 1'b1);
        check_flag("pslverr", pslverr, err);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [7:0] exp);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready", pready, 1'b1);
        check_flag("pslverr", pslverr, 1'b0);
        check_byte("prdata", prdata, exp);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Identity colours offset by the palette number
    task automatic prog_palette();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            prog_en   <= 1'b1;
            prog_addr <= 8'(a);
            prog_data <= 4'(a[3:0] + a[7:4]);
        end
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    function automatic logic [12:0] tile_addr(input logic [9:0] idx, input logic [2:0] row);
        tile_attr_t a;
        a = tile_attr_t'(attr_mem[idx]);
        return {a.code_hi, code_mem[idx], row ^ {3{a.vflip}}};
    endfunction

    // Pixel g takes bit 3-(g%4) of the four nibbles of its half word
    function automatic logic [3:0] row_pixel(input logic [31:0] w, input int g);
        logic [3:0] p;
        int         half;
        half = (g < 4) ? 16 : 0;
        for (int i = 0; i < 4; i++) begin
            p[3-i] = w[half + 15 - 4*i - (g % 4)];
        end
        return p;
    endfunction

    function automatic logic [31:0] expected_colours(input tile_rec_t rec);
        logic [31:0] w;
        logic [31:0] c;
        int          g;
        w = rec.ok ? rom_word(rec.addr) : 32'h0;
        for (int j = 0; j < 8; j++) begin
            g = rec.hflip ? 7 - j : j;
            c[31-4*j -: 4] = row_pixel(w, g) + rec.palette;
        end
        return c;
    endfunction

    function automatic logic [31:0] window(input int s);
        logic [31:0] w;
        for (int j = 0; j < 8; j++) begin
            w[31-4*j -: 4] = pxl_q[s+j];
        end
        return w;
    endfunction

    // Finds where the tile's colours start in the captured stream
    task automatic match_tile(input tile_rec_t rec);
        logic [31:0] exp_c;
        int          start;
        int          first;
        exp_c = expected_colours(rec);
        start = -1;
        first = -1;
        for (int s = search_pos; s + 8 <= pxl_q.size(); s++) begin
            if (first < 0 && pxl_q[s] === exp_c[31:28]) first = s;
            if (start < 0 && window(s) === exp_c) start = s;
        end
        if (start < 0) start = first;   // Report the mismatch from the first candidate
        if (start < 0) begin
            $display("pixel row of the tile at ROM address %h never appeared on pxl", rec.addr);
            abort_run();
        end else begin
            for (int j = 0; j < 8; j++) begin
                check_pxl("pxl", pxl_q[start+j], exp_c[31-4*j -: 4]);
            end
            search_pos = start + 8;
        end
    endtask

    // One line from hdump 0 with a pixel enable every other clock
    task automatic run_line(input logic [7:0] v, input logic f, input int n_pix, input bit pix_on);
        logic [8:0] h;
        logic [7:0] hdf;
        logic [7:0] vsum;
        logic [9:0] idx;
        tile_attr_t a;
        tile_rec_t  rec;
        tile_q.delete();
        pxl_q.delete();
        @(posedge clk);
        hdump   <= 9'd0;
        vdump   <= v;
        flip    <= f;
        pxl_cen <= 1'b0;
        for (int i = 0; i < n_pix; i++) begin
            h = 9'(i);
            @(posedge clk);
            pxl_cen <= 1'b1;
            @(posedge clk);          // Enable edge for this hdump
            pxl_cen <= 1'b0;
            hdump   <= h + 9'd1;
            hdf  = {8{f}} ^ h[7:0];
            idx  = {m_vscr[7:3], hdf[7:3]};
            vsum = v + vscroll_val;
            if (hdf[2:0] == 3'd0) exp_addr = tile_addr(idx, m_vscr[2:0]);
            if (pix_on && hdf[2:0] == 3'd4 && i <= n_pix - 11) begin
                a = tile_attr_t'(attr_mem[idx]);
                rec.addr    = exp_addr;
                rec.hflip   = a.hflip;
                rec.palette = a.palette;
                rec.ok      = rom_ok_en;
                tile_q.push_back(rec);
            end
            if (h[8]) m_vscr = {8{f}} ^ v;
            else if (h[5]) m_vscr = {8{f}} ^ vsum;
            @(negedge clk);
            if (hdf[2:0] == 3'd0) check_addr("rom_addr", rom_addr, exp_addr);
            if (pix_on) pxl_q.push_back(pxl);
        end
        search_pos = 0;
        foreach (tile_q[t]) match_tile(tile_q[t]);
    endtask

    task automatic register_readback();
        logic [7:0] d;
        for (int i = 0; i < 1024; i++) begin
            d = 8'($urandom);
            code_mem[i] = d;
            apb_write(ADDR_CODE_BASE + 12'(i), d, 1'b0);
            d = 8'($urandom);
            attr_mem[i] = d;
            apb_write(ADDR_ATTR_BASE + 12'(i), d, 1'b0);
        end
        vscroll_val = 8'($urandom);
        apb_write(ADDR_VSCROLL, vscroll_val, 1'b0);
        apb_write(12'hc05, 8'($urandom), 1'b1);   // Would alias code 5 with a loose decode
        for (int i = 0; i < 4; i++) begin
            apb_write(12'h801 + 12'($urandom % 2047), 8'($urandom), 1'b1);
        end
        for (int i = 0; i < 1024; i++) begin
            apb_read(ADDR_CODE_BASE + 12'(i), code_mem[i]);
            apb_read(ADDR_ATTR_BASE + 12'(i), attr_mem[i]);
        end
        apb_read(ADDR_VSCROLL, vscroll_val);
    endtask

    task automatic set_scroll(input logic [7:0] s);
        vscroll_val = s;
        apb_write(ADDR_VSCROLL, s, 1'b0);
    endtask

    task automatic vflip_line(input logic [7:0] v);
        logic [9:0] idx;
        tile_attr_t a;
        idx = {v[7:3], 5'd1};            // Tile under hdump 264 in the fixed columns
        a = tile_attr_t'(attr_mem[idx]);
        a.vflip = 1'b1;
        attr_mem[idx] = 8'(a);
        apb_write(ADDR_ATTR_BASE + 12'(idx), 8'(a), 1'b0);
        run_line(v, 1'b0, 512, 1'b1);
    endtask

    initial begin
        rst       = 1'b1;
        paddr     = 12'h000;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = 8'h00;
        prog_addr = 8'h00;
        prog_data = 4'h0;
        prog_en   = 1'b0;
        hdump     = 9'd0;
        vdump     = 8'd0;
        flip      = 1'b0;
        pxl_cen   = 1'b0;
        void'($urandom(32'hdecf40b8));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        register_readback();
        set_scroll(8'h00);
        run_line(8'($urandom), 1'b0, 512, 1'b0);
        set_scroll(8'($urandom) | 8'h01);
        run_line(8'($urandom), 1'b0, 512, 1'b0);
        prog_palette();
        run_line(8'($urandom), 1'b0, 512, 1'b1);
        run_line(8'($urandom), 1'b0, 512, 1'b1);
        vflip_line(8'($urandom));
        run_line(8'($urandom), 1'b1, 512, 1'b1);
        @(posedge clk);
        rom_ok_en <= 1'b0;               // ROM never ready so rows come out blank
        run_line(8'($urandom), 1'b0, 256, 1'b1);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* scroll_layer.f */
src/scroll_pkg.sv
src/tile_vram.sv
src/tile_fetch.sv
src/pixel_shifter.sv
src/palette_lut.sv
src/scroll_layer.sv
tests/tb_scroll_layer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_scroll_layer
FILELIST  = scroll_layer.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TB FAILED" $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
